// ==== design/isa_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction set of the 16-bit teaching core
// Opcode and ALU function encodings, register index and data word
// R and I views of an instruction word as one packed union
//////////////////////////////////////////////////////////////////////
package isa_pkg;

   // Major opcode, bits 15:11
   typedef enum logic [4:0] {
      HALT  = 5'd0,
      NOP   = 5'd1,
      ALU_R = 5'd2,
      ADDI  = 5'd3,
      SUBI  = 5'd4,
      J     = 5'd5,
      BEQZ  = 5'd6
   } opcode_e;

   // ALU_R function select, bits 1:0
   typedef enum logic [1:0] {
      ADD = 2'd0,
      SUB = 2'd1,
      AND = 2'd2,
      XOR = 2'd3
   } func_e;

   typedef logic [2:0]        reg_idx_t;
   typedef logic [15:0]       word_t;
   typedef logic signed [4:0] imm_t;

   // Register form, rd = rs func rt
   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      func_e    func;
   } r_view_t;

   // Immediate form, also J and BEQZ offsets in words
   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t rd;
      reg_idx_t rs;
      imm_t     imm;
   } i_view_t;

   typedef union packed {
      r_view_t r;
      i_view_t i;
   } instr_u;

   // Pipeline bubble
   localparam instr_u NOP_WORD = instr_u'({NOP, 11'd0});

endpackage

// ==== design/pipe_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline records of the core
// Load and retire stream payloads
// Fetch/decode, decode/execute and execute/result stage records
//////////////////////////////////////////////////////////////////////
package pipe_pkg;

   // Word address of the instruction memory
   typedef logic [7:0] pc_t;

   // One program word from the load port
   typedef struct packed {
      pc_t             addr;
      isa_pkg::instr_u word;
   } load_t;

   // One retired register write
   typedef struct packed {
      pc_t               pc;
      isa_pkg::reg_idx_t rd;
      isa_pkg::word_t    value;
   } retire_t;

   typedef struct packed {
      logic            valid;
      pc_t             pc;
      isa_pkg::instr_u instr;
   } fd_t;

   // Operands already read, imm sign extended
   typedef struct packed {
      logic              valid;
      pc_t               pc;
      isa_pkg::opcode_e  opcode;
      isa_pkg::func_e    func;
      isa_pkg::reg_idx_t rd;
      logic              writes_rd;
      isa_pkg::word_t    operand_a;
      isa_pkg::word_t    operand_b;
      isa_pkg::word_t    imm;
   } de_t;

   // Only register writes travel past execute
   typedef struct packed {
      logic              valid;
      pc_t               pc;
      isa_pkg::reg_idx_t rd;
      isa_pkg::word_t    value;
   } er_t;

endpackage

// ==== design/fetch_stage.sv ====
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Fetch stage
// PC register and word-addressed instruction memory with load port
// RAW hazard check against in-flight writers, NOP bubble insertion
// Halt latch, cleared by a run rising edge or a redirect
//////////////////////////////////////////////////////////////////////
module fetch_stage #(
   parameter int IMEM_DEPTH = 256
) (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    run,
   input  logic                    load_valid,
   input  pipe_pkg::load_t         load,
   output logic                    load_ready,
   input  logic                    stall,
   input  logic                    redirect,
   input  pipe_pkg::pc_t           redirect_pc,
   input  isa_pkg::reg_idx_t [2:0] hz_dst,
   input  logic [2:0]              hz_dst_valid,
   output pipe_pkg::fd_t           fd
);

   localparam int AW = $clog2(IMEM_DEPTH);

   isa_pkg::instr_u  mem [IMEM_DEPTH];
   pipe_pkg::pc_t    pc;
   logic             run_q;
   logic             halt_q;
   logic             start;
   logic             active;
   isa_pkg::instr_u  cur;
   isa_pkg::opcode_e op;
   logic             rs_used;
   logic             rt_used;
   logic [2:0]       raw;
   logic             bubble;

   //////////////////////////////////////////////////////////////////////
   // Instruction memory
   //////////////////////////////////////////////////////////////////////

   // Program loads only while the core is stopped
   assign load_ready = ~run;

   always_ff @(posedge clk) begin
      if (load_valid && load_ready) begin
         mem[load.addr[AW-1:0]] <= load.word;
      end
   end

   // Asynchronous read at the PC
   assign cur = mem[pc[AW-1:0]];
   assign op  = cur.r.opcode;

   //////////////////////////////////////////////////////////////////////
   // RAW detection
   //////////////////////////////////////////////////////////////////////

   // Which source fields the opcode really reads
   always_comb begin
      rs_used = 1'b0;
      rt_used = 1'b0;
      case (op)
         isa_pkg::ALU_R: begin
            rs_used = 1'b1;
            rt_used = 1'b1;
         end
         isa_pkg::ADDI, isa_pkg::SUBI, isa_pkg::BEQZ: begin
            rs_used = 1'b1;
         end
         default: ;
      endcase
   end

   // Slot 0 decode, slot 1 execute, slot 2 pending write-back
   always_comb begin
      for (int i = 0; i < 3; i++) begin
         raw[i] = hz_dst_valid[i] &&
                  ((rs_used && (cur.r.rs == hz_dst[i])) ||
                   (rt_used && (cur.r.rt == hz_dst[i])));
      end
   end

   assign bubble = |raw;

   //////////////////////////////////////////////////////////////////////
   // PC, halt latch and fetch record
   //////////////////////////////////////////////////////////////////////

   // Run edge restarts at PC 0, first issue one cycle later
   assign start  = run & ~run_q;
   assign active = run & run_q & ~halt_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run_q  <= 1'b0;
         halt_q <= 1'b0;
         pc     <= '0;
         fd     <= '0;
      end else begin
         run_q <= run;
         if (start) begin
            pc     <= '0;
            halt_q <= 1'b0;
            fd     <= '{valid: 1'b0, pc: '0, instr: isa_pkg::NOP_WORD};
         end else if (!stall) begin
            if (redirect) begin
               // Taken transfer, anything fetched here is wrong path
               pc     <= redirect_pc;
               halt_q <= 1'b0;
               fd     <= '{valid: 1'b0, pc: pc, instr: isa_pkg::NOP_WORD};
            end else if (active && !bubble) begin
               fd <= '{valid: 1'b1, pc: pc, instr: cur};
               // PC parks on HALT
               if (op == isa_pkg::HALT) begin
                  halt_q <= 1'b1;
               end else begin
                  pc <= pc + 8'd1;
               end
            end else begin
               // Hazard or idle, PC holds
               fd <= '{valid: 1'b0, pc: pc, instr: isa_pkg::NOP_WORD};
            end
         end
      end
   end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Decode stage
// Eight-entry register file, write before read
// R or I view decode of the fetched word into the execute record
//////////////////////////////////////////////////////////////////////
module decode_stage (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              stall,
   input  logic              flush,
   input  pipe_pkg::fd_t     fd,
   input  logic              wb_valid,
   input  isa_pkg::reg_idx_t wb_rd,
   input  isa_pkg::word_t    wb_value,
   output pipe_pkg::de_t     de,
   output isa_pkg::reg_idx_t dst,
   output logic              dst_valid
);

   isa_pkg::word_t   rf [8];
   isa_pkg::opcode_e op;
   logic             is_r;
   logic             writes;
   isa_pkg::word_t   rs_val;
   isa_pkg::word_t   rt_val;
   isa_pkg::word_t   imm_ext;

   //////////////////////////////////////////////////////////////////////
   // Register file
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 8; i++) begin
            rf[i] <= '0;
         end
      end else if (wb_valid) begin
         rf[wb_rd] <= wb_value;
      end
   end

   // Same-cycle write wins over the stored value
   always_comb begin
      rs_val = rf[fd.instr.r.rs];
      rt_val = rf[fd.instr.r.rt];
      if (wb_valid && (wb_rd == fd.instr.r.rs)) begin
         rs_val = wb_value;
      end
      if (wb_valid && (wb_rd == fd.instr.r.rt)) begin
         rt_val = wb_value;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Control decode
   //////////////////////////////////////////////////////////////////////

   assign op   = fd.instr.r.opcode;
   assign is_r = (op == isa_pkg::ALU_R);

   // I view offset, sign extended to a word
   assign imm_ext = {{11{fd.instr.i.imm[4]}}, fd.instr.i.imm};

   assign writes = is_r || (op == isa_pkg::ADDI) || (op == isa_pkg::SUBI);

   // Writer now in decode, for the fetch hazard check
   assign dst       = fd.instr.r.rd;
   assign dst_valid = fd.valid & writes;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         de <= '0;
      end else if (!stall) begin
         if (flush) begin
            de.valid <= 1'b0;
         end else begin
            de <= '{valid:     fd.valid,
                    pc:        fd.pc,
                    opcode:    op,
                    func:      fd.instr.r.func,
                    rd:        fd.instr.r.rd,
                    writes_rd: writes,
                    operand_a: rs_val,
                    operand_b: is_r ? rt_val : imm_ext,
                    imm:       imm_ext};
         end
      end
   end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Execute stage
// ALU for ALU_R, ADDI and SUBI
// J and BEQZ resolution, redirect to fetch, HALT detection
//////////////////////////////////////////////////////////////////////
module execute_stage (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              stall,
   input  pipe_pkg::de_t     de,
   output pipe_pkg::er_t     er,
   output logic              redirect,
   output pipe_pkg::pc_t     redirect_pc,
   output isa_pkg::reg_idx_t dst,
   output logic              dst_valid,
   output logic              halt_seen
);

   isa_pkg::word_t alu_out;
   logic           taken;

   // ALU, operand_b already holds rt or the immediate
   always_comb begin
      case (de.opcode)
         isa_pkg::ALU_R: begin
            case (de.func)
               isa_pkg::ADD: alu_out = de.operand_a + de.operand_b;
               isa_pkg::SUB: alu_out = de.operand_a - de.operand_b;
               isa_pkg::AND: alu_out = de.operand_a & de.operand_b;
               default:      alu_out = de.operand_a ^ de.operand_b;
            endcase
         end
         isa_pkg::ADDI: alu_out = de.operand_a + de.operand_b;
         isa_pkg::SUBI: alu_out = de.operand_a - de.operand_b;
         default:       alu_out = '0;
      endcase
   end

   // J always, BEQZ on a zero rs
   assign taken = de.valid &&
                  ((de.opcode == isa_pkg::J) ||
                   ((de.opcode == isa_pkg::BEQZ) && (de.operand_a == '0)));

   assign redirect    = taken;
   // Target is PC + 1 + imm in words
   assign redirect_pc = de.pc + 8'd1 + de.imm[7:0];

   // Writer now in execute, for the fetch hazard check
   assign dst       = de.rd;
   assign dst_valid = de.valid & de.writes_rd;

   assign halt_seen = de.valid && (de.opcode == isa_pkg::HALT);

   // Only register writes go on to result
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         er <= '0;
      end else if (!stall) begin
         er <= '{valid: dst_valid, pc: de.pc, rd: de.rd, value: alu_out};
      end
   end

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Result stage
// Register write-back and retire output register
// Pipeline stall from retire back-pressure, halted flag
//////////////////////////////////////////////////////////////////////
module result_stage (
   input  logic              clk,
   input  logic              arst_n,
   input  pipe_pkg::er_t     er,
   input  logic              retire_ready,
   input  logic              halt_seen,
   output logic              retire_valid,
   output pipe_pkg::retire_t retire,
   output logic              stall,
   output logic              wb_valid,
   output isa_pkg::reg_idx_t wb_rd,
   output isa_pkg::word_t    wb_value,
   output logic              halted
);

   logic halt_req;

   // Full retire register that is not taken freezes everything
   assign stall = retire_valid & ~retire_ready;

   // Write-back straight from the execute record
   assign wb_valid = er.valid;
   assign wb_rd    = er.rd;
   assign wb_value = er.value;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         retire_valid <= 1'b0;
      end else if (!stall) begin
         retire_valid <= er.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         retire <= '{pc: er.pc, rd: er.rd, value: er.value};
      end
   end

   // Halted once nothing older is left after this edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halt_req <= 1'b0;
         halted   <= 1'b0;
      end else begin
         if (halt_seen) begin
            halt_req <= 1'b1;
         end
         if ((halt_seen || halt_req) && !stall && !er.valid) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Top level of the 16-bit pipelined core
// Fetch, decode, execute and result stages with shared stall
//////////////////////////////////////////////////////////////////////
module cpu_top #(
   parameter int IMEM_DEPTH = 256
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              load_valid,
   output logic              load_ready,
   input  pipe_pkg::load_t   load,
   input  logic              run,
   output logic              retire_valid,
   input  logic              retire_ready,
   output pipe_pkg::retire_t retire,
   output logic              halted
);

   // Stage records
   pipe_pkg::fd_t     fd;
   pipe_pkg::de_t     de;
   pipe_pkg::er_t     er;

   // Stall, redirect and halt
   logic              stall;
   logic              redirect;
   pipe_pkg::pc_t     redirect_pc;
   logic              halt_seen;

   // In-flight destinations and write-back
   isa_pkg::reg_idx_t dec_dst;
   logic              dec_dst_valid;
   isa_pkg::reg_idx_t ex_dst;
   logic              ex_dst_valid;
   logic              wb_valid;
   isa_pkg::reg_idx_t wb_rd;
   isa_pkg::word_t    wb_value;

   fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
      .clk(clk), .arst_n(arst_n), .run(run),
      .load_valid(load_valid), .load(load), .load_ready(load_ready),
      .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
      // Slot order decode, execute, write-back
      .hz_dst({wb_rd, ex_dst, dec_dst}),
      .hz_dst_valid({wb_valid, ex_dst_valid, dec_dst_valid}),
      .fd(fd)
   );

   decode_stage u_decode (
      .clk(clk), .arst_n(arst_n), .stall(stall), .flush(redirect), .fd(fd),
      .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_value(wb_value),
      .de(de), .dst(dec_dst), .dst_valid(dec_dst_valid)
   );

   execute_stage u_execute (
      .clk(clk), .arst_n(arst_n), .stall(stall), .de(de), .er(er),
      .redirect(redirect), .redirect_pc(redirect_pc),
      .dst(ex_dst), .dst_valid(ex_dst_valid), .halt_seen(halt_seen)
   );

   result_stage u_result (
      .clk(clk), .arst_n(arst_n), .er(er), .retire_ready(retire_ready),
      .halt_seen(halt_seen), .retire_valid(retire_valid), .retire(retire),
      .stall(stall), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_value(wb_value),
      .halted(halted)
   );

endmodule

// ==== dv/cpu_tb.sv ====
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Testbench of the pipelined core
// Clock, reset, directed and random programs, load port driver
// ISA reference model and assertions on the retire stream
//////////////////////////////////////////////////////////////////////
module cpu_tb;

   localparam int GUARD_CYCLES = 24;
   localparam int HALT_TIMEOUT = 3000;

   logic              clk = 1'b0;
   logic              arst_n;
   logic              load_valid;
   logic              load_ready;
   pipe_pkg::load_t   load;
   logic              run;
   logic              retire_valid;
   logic              retire_ready = 1'b1;
   pipe_pkg::retire_t retire;
   logic              halted;

   isa_pkg::instr_u   prog [256];
   pipe_pkg::retire_t exp_q [$];
   bit                ready_random;
   int                prog_id;
   int                seen_id;
   int                exp_idx;
   int                checks_done;

   cpu_top #(.IMEM_DEPTH(256)) uut (
      .clk(clk), .arst_n(arst_n), .load_valid(load_valid), .load_ready(load_ready),
      .load(load), .run(run), .retire_valid(retire_valid),
      .retire_ready(retire_ready), .retire(retire), .halted(halted)
   );

   // 40 ns clock
   always #20 clk = ~clk;

   // Random back-pressure on about one cycle in three
   always @(posedge clk) begin
      #2;
      retire_ready = ready_random ? ($urandom_range(0, 2) != 0) : 1'b1;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "simulation stopped");
   endtask

   function automatic isa_pkg::instr_u enc_r(input isa_pkg::reg_idx_t rd,
         input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt, input isa_pkg::func_e f);
      isa_pkg::instr_u w;
      w.r = '{opcode: isa_pkg::ALU_R, rd: rd, rs: rs, rt: rt, func: f};
      return w;
   endfunction

   function automatic isa_pkg::instr_u enc_i(input isa_pkg::opcode_e op,
         input isa_pkg::reg_idx_t rd, input isa_pkg::reg_idx_t rs, input isa_pkg::imm_t imm);
      isa_pkg::instr_u w;
      w.i = '{opcode: op, rd: rd, rs: rs, imm: imm};
      return w;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Program generation and reference model
   //////////////////////////////////////////////////////////////////////

   // Random body of n words with a HALT at index n
   // Jump and branch offsets stay forward
   task automatic gen_program(input int n, input bit chain);
      int                kind;
      int                maxoff;
      isa_pkg::reg_idx_t rd;
      isa_pkg::reg_idx_t rs;
      isa_pkg::reg_idx_t rt;
      isa_pkg::reg_idx_t last_rd;
      last_rd = 3'd1;
      for (int i = 0; i < n; i++) begin
         kind   = int'($urandom_range(0, 9));
         rd     = 3'($urandom_range(0, 7));
         rs     = 3'($urandom_range(0, 7));
         rt     = 3'($urandom_range(0, 7));
         maxoff = (n - 1 - i < 15) ? n - 1 - i : 15;
         // Chain mode reads the last written register
         if (chain) begin
            rs = last_rd;
            rt = last_rd;
         end
         case (kind)
            0, 1, 2, 3: prog[i] = enc_r(rd, rs, rt, isa_pkg::func_e'(2'(kind)));
            4: prog[i] = enc_i(isa_pkg::ADDI, rd, rs, 5'($urandom_range(0, 31)));
            5: prog[i] = enc_i(isa_pkg::SUBI, rd, rs, 5'($urandom_range(0, 31)));
            6: prog[i] = enc_i(isa_pkg::J, rd, rs, 5'($urandom_range(0, maxoff)));
            7: prog[i] = enc_i(isa_pkg::BEQZ, rd, rs, 5'($urandom_range(0, maxoff)));
            8: prog[i] = isa_pkg::NOP_WORD;
            default: prog[i] = enc_i(isa_pkg::ADDI, rd, rs, 5'($urandom_range(0, 31)));
         endcase
         if (kind < 6 || kind == 9) begin
            last_rd = rd;
         end
      end
      prog[n] = enc_i(isa_pkg::HALT, 3'd0, 3'd0, 5'd0);
   endtask

   // Sequential ISA execution
   // One expected record per register write
   task automatic build_expected();
      isa_pkg::word_t  regs [8];
      isa_pkg::instr_u w;
      isa_pkg::word_t  a;
      isa_pkg::word_t  b;
      isa_pkg::word_t  v;
      int              pc;
      int              off;
      bit              done;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      exp_q.delete();
      pc   = 0;
      done = 1'b0;
      while (!done && pc < 256) begin
         w   = prog[pc];
         a   = regs[w.r.rs];
         b   = regs[w.r.rt];
         off = int'(w.i.imm);
         v   = '0;
         case (w.r.opcode)
            isa_pkg::ALU_R: begin
               case (w.r.func)
                  isa_pkg::ADD: v = a + b;
                  isa_pkg::SUB: v = a - b;
                  isa_pkg::AND: v = a & b;
                  default:      v = a ^ b;
               endcase
            end
            isa_pkg::ADDI: v = a + 16'(off);
            isa_pkg::SUBI: v = a - 16'(off);
            default: ;
         endcase
         if (w.r.opcode inside {isa_pkg::ALU_R, isa_pkg::ADDI, isa_pkg::SUBI}) begin
            regs[w.r.rd] = v;
            exp_q.push_back('{pc: 8'(pc), rd: w.r.rd, value: v});
         end
         if (w.r.opcode == isa_pkg::HALT) begin
            done = 1'b1;
         end else if (w.r.opcode == isa_pkg::J || (w.r.opcode == isa_pkg::BEQZ && a == '0)) begin
            pc = pc + 1 + off;
         end else begin
            pc = pc + 1;
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Load port, program run and checks
   //////////////////////////////////////////////////////////////////////

   // Words 0 to n, entered 2 ns after a rising edge
   task automatic load_program(input int n);
      int t;
      for (int i = 0; i <= n; i++) begin
         load_valid = 1'b1;
         load       = '{addr: 8'(i), word: prog[i]};
         t = 0;
         @(negedge clk);
         while (!load_ready) begin
            t++;
            if (t > 16) abort_run("load port never accepted a program word");
            @(negedge clk);
         end
         @(posedge clk);
         #2;
      end
      load_valid = 1'b0;
   endtask

   task automatic run_program(input int n, input bit random_ready);
      int t;
      arst_n     = 1'b0;
      run        = 1'b0;
      load_valid = 1'b0;
      repeat (16) @(posedge clk);
      #2 arst_n = 1'b1;
      @(negedge clk);
      assert (!retire_valid && !halted) else abort_run("retire_valid or halted high after reset");
      @(posedge clk);
      #2;
      load_program(n);
      build_expected();
      prog_id++;
      ready_random = random_ready;
      run          = 1'b1;
      // Word offered while running would overwrite the HALT if taken
      load_valid   = 1'b1;
      load         = '{addr: 8'(n), word: enc_i(isa_pkg::ADDI, 3'd1, 3'd1, 5'd1)};
      t = 0;
      @(negedge clk);
      while (!halted) begin
         t++;
         if (t > HALT_TIMEOUT) abort_run("halted never rose");
         @(negedge clk);
      end
      assert (exp_idx == exp_q.size()) else abort_run("halted rose before all expected retires");
      // No retire may follow halted in the guard window
      repeat (GUARD_CYCLES) @(negedge clk);
      @(posedge clk);
      #2;
      load_valid   = 1'b0;
      run          = 1'b0;
      ready_random = 1'b0;
   endtask

   // Handshake seen here completes on the next rising edge
   always @(negedge clk) begin
      if (prog_id != seen_id) begin
         seen_id = prog_id;
         exp_idx = 0;
      end
      if (!arst_n) begin
         assert (!retire_valid && !halted) else abort_run("retire_valid or halted high in reset");
      end else begin
         assert (load_ready == !run) else abort_run("load_ready does not follow run");
         if (halted) begin
            assert (!retire_valid) else abort_run("retire_valid raised after halted");
         end
         if (retire_valid && retire_ready) begin
            assert (exp_idx < exp_q.size()) else abort_run("retire record with none expected");
            assert (retire == exp_q[exp_idx]) else begin
               abort_run({$sformatf("MISMATCH at %0t: got pc %0d rd %0d value %h",
                                    $time, retire.pc, retire.rd, retire.value),
                          $sformatf(", expected pc %0d rd %0d value %h",
                                    exp_q[exp_idx].pc, exp_q[exp_idx].rd,
                                    exp_q[exp_idx].value)});
            end
            exp_idx++;
            checks_done++;
         end
      end
   end

   initial begin
      void'($urandom(32'hf83350f1));
      arst_n     = 1'b0;
      run        = 1'b0;
      load_valid = 1'b0;
      load       = '0;
      // Directed program with a J, a taken BEQZ and a not-taken BEQZ
      prog[0] = enc_i(isa_pkg::ADDI, 3'd1, 3'd0, 5'd5);
      prog[1] = enc_i(isa_pkg::BEQZ, 3'd0, 3'd1, 5'd1);
      prog[2] = enc_i(isa_pkg::J, 3'd0, 3'd0, 5'd1);
      prog[3] = enc_i(isa_pkg::ADDI, 3'd2, 3'd0, 5'd7);
      prog[4] = enc_i(isa_pkg::BEQZ, 3'd0, 3'd0, 5'd1);
      prog[5] = enc_i(isa_pkg::ADDI, 3'd3, 3'd0, 5'd9);
      prog[6] = enc_i(isa_pkg::SUBI, 3'd4, 3'd1, 5'd3);
      prog[7] = enc_r(3'd5, 3'd4, 3'd1, isa_pkg::SUB);
      prog[8] = enc_i(isa_pkg::HALT, 3'd0, 3'd0, 5'd0);
      run_program(8, 1'b0);
      // Random programs with odd ones chained
      // Back-pressure on the last four
      for (int p = 0; p < 8; p++) begin
         int n;
         n = int'($urandom_range(8, 30));
         gen_program(n, (p % 2) == 1);
         run_program(n, p >= 4);
      end
      if (checks_done > 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         abort_run("no retire record was checked");
      end
   end

endmodule

// ==== sim.f ====
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/cpu_top.sv
dv/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and search the output for the pass line
verilator --binary --timing --assert -f sim.f --top-module cpu_tb -o cpu_tb_sim &&
./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -q "Testbench passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
